// ==== compile.f ====
hdl/vision_pkg.sv
hdl/video_timing.sv
hdl/vram_arbiter.sv
hdl/vram_pixel_fetch.sv
hdl/marker_overlay.sv
hdl/video_out.sv
hdl/cue_display_top.sv
verification/cue_display_assert.sv
verification/cue_display_tb.sv

// ==== Makefile ====
TOP = cue_display_tb
OBJ = obj_dir
LOG = sim.log

all: run

build:
	verilator --binary --timing --assert -j 0 -f compile.f --top-module $(TOP) -Mdir $(OBJ)

# The run passes only if the pass line appears in the log
run: build
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

lint:
	verilator --lint-only --timing --assert -Wall -f compile.f --top-module $(TOP)

clean:
	rm -rf $(OBJ) $(LOG)

.PHONY: all build run lint clean

// ==== verification/cue_display_tb.sv ====
`timescale 1ns/1ns

module cue_display_tb;
   import vision_pkg::*;

   // Small 16x4 frame with short porches
   localparam int H_ACTIVE  = 16;
   localparam int H_FP      = 2;
   localparam int H_SYNC    = 4;
   localparam int H_BP      = 2;
   localparam int V_ACTIVE  = 4;
   localparam int V_FP      = 1;
   localparam int V_SYNC    = 2;
   localparam int V_BP      = 1;
   localparam int N_MARKERS = 2;
   localparam int H_TOTAL   = H_ACTIVE + H_FP + H_SYNC + H_BP;
   localparam int V_TOTAL   = V_ACTIVE + V_FP + V_SYNC + V_BP;
   localparam int WORDS     = H_ACTIVE / 4;
   // Twelve frame waits in the stimulus, two spare
   localparam int N_FRAMES   = 14;
   localparam int TIMEOUT_NS = (N_FRAMES * H_TOTAL * V_TOTAL + 100) * 8;

   logic       clk;
   logic       arst_n;
   logic       pattern_en;
   logic       pattern_period;
   logic       bars_sel;
   coord_t     marker_left   [N_MARKERS];
   coord_t     marker_right  [N_MARKERS];
   coord_t     marker_top    [N_MARKERS];
   coord_t     marker_bottom [N_MARKERS];
   vram_addr_t vram_addr;
   logic       vram_we;
   vram_word_t vram_wdata;
   vram_word_t vram_rdata;
   pixel_t     vga_gray;
   logic       vga_hsync_n;
   logic       vga_vsync_n;
   logic       vga_blank_n;

   vram_word_t mem [int];
   vram_addr_t rd_addr_q;
   vram_addr_t exp_wr_addr;
   logic [15:0] lfsr;
   logic       check_en;
   int         errors;
   int         checks;
   int         writes;
   // Output raster tracking
   int         out_h;
   int         out_v;
   int         hs_len;
   int         vs_len;
   logic       blank_n_q;
   logic       hs_q;
   logic       vs_q;

   cue_display_top #(
      .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
      .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
      .N_MARKERS(N_MARKERS)
   ) cue_display_top_i (.*);

   always #4 clk = ~clk;

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   // 16-bit Fibonacci LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // Unwritten SRAM words read as zero
   function automatic vram_word_t mem_read(vram_addr_t a);
      if (mem.exists(int'(a))) begin
         return mem[int'(a)];
      end else begin
         return '0;
      end
   endfunction

   // Test-pattern word for a given write count
   function automatic vram_word_t pattern_word(vram_addr_t c, logic period);
      pixel_t b;
      b = period ? {c[6:3], 4'h0} : {c[7:4], 4'h0};
      return {4{b}};
   endfunction

   // Expected grey level at active position h, v
   function automatic pixel_t ref_pixel(int h, int v);
      coord_t     hb;
      vram_word_t w;
      pixel_t     p;
      hb = coord_t'(h);
      if (bars_sel) begin
         return {hb[BAR_SHIFT +: 3], 5'b00000};
      end
      w = mem_read(vram_addr_t'(v * WORDS + h / 4));
      p = w[8 * (h % 4) +: 8];
      for (int m = 0; m < N_MARKERS; m++) begin
         if (h >= int'(marker_left[m]) && h < int'(marker_right[m]) &&
             v >= int'(marker_top[m]) && v < int'(marker_bottom[m])) begin
            p = p | MARKER_LEVEL;
         end
      end
      return p;
   endfunction

   task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t ns: %s got %0h expected %0h", $time, what, got, exp);
      end
   endtask

   // One LFSR step per data bit
   task automatic load_memory();
      vram_word_t w;
      for (int a = 0; a < V_ACTIVE * WORDS; a++) begin
         for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);
            w = {w[30:0], lfsr[0]};
         end
         mem[a] = w;
      end
   endtask

   task automatic set_marker(int m, int l, int r, int t, int b);
      marker_left[m]   <= coord_t'(l);
      marker_right[m]  <= coord_t'(r);
      marker_top[m]    <= coord_t'(t);
      marker_bottom[m] <= coord_t'(b);
   endtask

   // Returns on the negedge that first sees vga_vsync_n low
   task automatic wait_vsync();
      logic prev;
      @(negedge clk);
      prev = vga_vsync_n;
      @(negedge clk);
      while (!(prev && !vga_vsync_n)) begin
         prev = vga_vsync_n;
         @(negedge clk);
      end
   endtask

   //////////////////////////////////////////////////
   // SRAM model and monitors
   //////////////////////////////////////////////////

   // Write lands at once, read data two edges after the address
   always @(posedge clk) begin
      if (vram_we) begin
         mem[int'(vram_addr)] = vram_wdata;
      end
      rd_addr_q  <= vram_addr;
      vram_rdata <= mem_read(rd_addr_q);
   end

   // Pattern writes follow the write counter
   always @(negedge clk) begin
      if (arst_n && vram_we) begin
         check_value("write address", 32'(vram_addr), 32'(exp_wr_addr));
         check_value("write data", vram_wdata, pattern_word(exp_wr_addr, pattern_period));
         exp_wr_addr++;
         writes++;
      end
   end

   // Pixel compare and raster structure
   always @(negedge clk) begin
      if (arst_n) begin
         if (vga_blank_n) begin
            if (check_en) begin
               check_value($sformatf("pixel %0d,%0d", out_h, out_v), 32'(vga_gray),
                           32'(ref_pixel(out_h, out_v)));
            end
            out_h++;
         end else begin
            check_value("gray in blanking", 32'(vga_gray), 32'd0);
         end
         // End of an active line
         if (blank_n_q && !vga_blank_n) begin
            check_value("active pixels per line", out_h, H_ACTIVE);
            out_h = 0;
            out_v++;
         end
         if (!vga_hsync_n) begin
            hs_len++;
         end else if (!hs_q) begin
            check_value("hsync width", hs_len, H_SYNC);
            hs_len = 0;
         end
         if (!vga_vsync_n) begin
            vs_len++;
         end else if (!vs_q) begin
            check_value("vsync width", vs_len, V_SYNC * H_TOTAL);
            vs_len = 0;
         end
         // Start of vsync closes the frame
         if (vs_q && !vga_vsync_n) begin
            check_value("active lines per frame", out_v, V_ACTIVE);
            out_v = 0;
         end
         blank_n_q = vga_blank_n;
         hs_q      = vga_hsync_n;
         vs_q      = vga_vsync_n;
      end
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout after %0d ns, the video output stopped making progress", TIMEOUT_NS);
      $display("=== FAIL ===");
      $finish;
   end

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   initial begin
      clk         = 1'b0;
      lfsr        = 16'd71;
      errors      = 0;
      checks      = 0;
      writes      = 0;
      out_h       = 0;
      out_v       = 0;
      hs_len      = 0;
      vs_len      = 0;
      blank_n_q   = 1'b0;
      hs_q        = 1'b1;
      vs_q        = 1'b1;
      exp_wr_addr = '0;
      arst_n         <= 1'b0;
      pattern_en     <= 1'b0;
      pattern_period <= 1'b0;
      bars_sel       <= 1'b0;
      check_en       <= 1'b0;
      vram_rdata     <= '0;
      rd_addr_q      <= '0;
      for (int m = 0; m < N_MARKERS; m++) begin
         set_marker(m, 0, 0, 0, 0);
      end

      // Idle outputs while reset is held, and before the first active edge
      repeat (2) @(posedge clk);
      @(negedge clk);
      check_value("hsync_n in reset", 32'(vga_hsync_n), 32'd1);
      check_value("vsync_n in reset", 32'(vga_vsync_n), 32'd1);
      check_value("blank_n in reset", 32'(vga_blank_n), 32'd0);
      check_value("vram_we in reset", 32'(vram_we), 32'd0);
      @(posedge clk);
      arst_n <= 1'b1;
      @(negedge clk);
      check_value("hsync_n after reset", 32'(vga_hsync_n), 32'd1);
      check_value("vsync_n after reset", 32'(vga_vsync_n), 32'd1);
      check_value("blank_n after reset", 32'(vga_blank_n), 32'd0);
      check_value("vram_we after reset", 32'(vram_we), 32'd0);

      // Pattern writer, short period then long period
      wait_vsync();
      @(posedge clk);
      pattern_en     <= 1'b1;
      pattern_period <= 1'b1;
      wait_vsync();
      check_value("writes with short period", 32'(writes != 0), 32'd1);
      writes = 0;
      @(posedge clk);
      pattern_period <= 1'b0;
      wait_vsync();
      check_value("writes with long period", 32'(writes != 0), 32'd1);
      @(posedge clk);
      pattern_en <= 1'b0;

      // Frame buffer content over two frames
      wait_vsync();
      load_memory();
      @(posedge clk);
      check_en <= 1'b1;
      repeat (2) wait_vsync();

      // Two overlapping boxes
      @(posedge clk);
      set_marker(0, 2, 7, 1, 3);
      set_marker(1, 5, 12, 0, 2);
      repeat (2) wait_vsync();

      // One empty box and one on the bottom right corner
      @(posedge clk);
      set_marker(0, 3, 10, 3, 1);
      set_marker(1, 12, 16, 2, 4);
      repeat (2) wait_vsync();

      // Test bars hide memory and markers
      @(posedge clk);
      bars_sel <= 1'b1;
      repeat (2) wait_vsync();

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// ==== verification/cue_display_assert.sv ====
`timescale 1ns/1ns

module cue_display_assert #(
   parameter int H_ACTIVE = 800,
   parameter int V_ACTIVE = 600
) (
   input logic               clk,
   input logic               arst_n,
   input vision_pkg::coord_t hcount,
   input vision_pkg::coord_t vcount,
   input logic               vram_we,
   input logic               vga_hsync_n,
   input logic               vga_vsync_n,
   input logic               vga_blank_n
);

   //////////////////////////////////////////////////
   // Memory port
   //////////////////////////////////////////////////

   // Pattern writes only outside the visible area
   // Visible area decoded straight from the counters
   write_in_blank: assert property (@(posedge clk) disable iff (!arst_n)
      vram_we |-> ((hcount >= H_ACTIVE) || (vcount >= V_ACTIVE)))
      else $error("vram_we high during active video");

   // Writes sit two cycles after a read slot, halfway to the next one
   write_off_read_slot: assert property (@(posedge clk) disable iff (!arst_n)
      vram_we |-> ($past(hcount[1:0], 2) == 2'd0))
      else $error("vram_we high in a read slot");

   //////////////////////////////////////////////////
   // Outputs held in reset
   //////////////////////////////////////////////////

   sync_idle_in_reset: assert property (@(posedge clk)
      (!arst_n && $past(!arst_n)) |-> (vga_hsync_n && vga_vsync_n && !vga_blank_n))
      else $error("sync or blank active while reset is held");

endmodule

bind cue_display_top cue_display_assert #(
   .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)
) cue_display_assert_i (
   .clk(clk), .arst_n(arst_n), .hcount(hcount), .vcount(vcount), .vram_we(vram_we),
   .vga_hsync_n(vga_hsync_n), .vga_vsync_n(vga_vsync_n), .vga_blank_n(vga_blank_n)
);

// ==== hdl/cue_display_top.sv ====
`timescale 1ns/1ns

module cue_display_top #(
   parameter int H_ACTIVE  = 800,
   parameter int H_FP      = 40,
   parameter int H_SYNC    = 128,
   parameter int H_BP      = 88,
   parameter int V_ACTIVE  = 600,
   parameter int V_FP      = 1,
   parameter int V_SYNC    = 4,
   parameter int V_BP      = 23,
   parameter int N_MARKERS = 4
) (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   pattern_en,
   input  logic                   pattern_period,
   input  logic                   bars_sel,
   input  vision_pkg::coord_t     marker_left   [N_MARKERS],
   input  vision_pkg::coord_t     marker_right  [N_MARKERS],
   input  vision_pkg::coord_t     marker_top    [N_MARKERS],
   input  vision_pkg::coord_t     marker_bottom [N_MARKERS],
   output vision_pkg::vram_addr_t vram_addr,
   output logic                   vram_we,
   output vision_pkg::vram_word_t vram_wdata,
   input  vision_pkg::vram_word_t vram_rdata,
   output vision_pkg::pixel_t     vga_gray,
   output logic                   vga_hsync_n,
   output logic                   vga_vsync_n,
   output logic                   vga_blank_n
);
   import vision_pkg::*;

   // Derived geometry for the fetch
   // Line length must be a multiple of four pixels
   localparam int WORDS_PER_LINE = H_ACTIVE / PIX_PER_WORD;
   localparam int H_TOTAL        = H_ACTIVE + H_FP + H_SYNC + H_BP;
   localparam int V_TOTAL        = V_ACTIVE + V_FP + V_SYNC + V_BP;

   coord_t     hcount;
   coord_t     vcount;
   logic       hsync_n;
   logic       vsync_n;
   logic       blank;
   vram_addr_t rd_addr;
   pixel_t     fb_pixel;
   pixel_t     ov_pixel;

   //////////////////////////////////////////////////
   // Timing and memory access
   //////////////////////////////////////////////////

   video_timing #(
      .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
      .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
   ) video_timing_i (
      .clk(clk), .arst_n(arst_n), .hcount(hcount), .vcount(vcount),
      .hsync_n(hsync_n), .vsync_n(vsync_n), .blank(blank)
   );

   vram_pixel_fetch #(
      .H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL), .WORDS_PER_LINE(WORDS_PER_LINE)
   ) vram_pixel_fetch_i (
      .clk(clk), .arst_n(arst_n), .hcount(hcount), .vcount(vcount),
      .vram_rdata(vram_rdata), .rd_addr(rd_addr), .fb_pixel(fb_pixel)
   );

   vram_arbiter vram_arbiter_i (
      .clk(clk), .arst_n(arst_n), .hcount(hcount), .blank(blank),
      .pattern_en(pattern_en), .pattern_period(pattern_period), .rd_addr(rd_addr),
      .vram_addr(vram_addr), .vram_we(vram_we), .vram_wdata(vram_wdata)
   );

   //////////////////////////////////////////////////
   // Pixel path
   //////////////////////////////////////////////////

   marker_overlay #(
      .N_MARKERS(N_MARKERS)
   ) marker_overlay_i (
      .clk(clk), .arst_n(arst_n), .hcount_d(hcount), .vcount_d(vcount),
      .fb_pixel(fb_pixel), .marker_left(marker_left), .marker_right(marker_right),
      .marker_top(marker_top), .marker_bottom(marker_bottom), .ov_pixel(ov_pixel)
   );

   video_out video_out_i (
      .clk(clk), .arst_n(arst_n), .bars_sel(bars_sel), .ov_pixel(ov_pixel),
      .hcount(hcount), .hsync_n(hsync_n), .vsync_n(vsync_n), .blank(blank),
      .vga_gray(vga_gray), .vga_hsync_n(vga_hsync_n), .vga_vsync_n(vga_vsync_n),
      .vga_blank_n(vga_blank_n)
   );

endmodule

// ==== hdl/video_out.sv ====
`timescale 1ns/1ns

module video_out (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               bars_sel,
   input  vision_pkg::pixel_t ov_pixel,
   input  vision_pkg::coord_t hcount,
   input  logic               hsync_n,
   input  logic               vsync_n,
   input  logic               blank,
   output vision_pkg::pixel_t vga_gray,
   output logic               vga_hsync_n,
   output logic               vga_vsync_n,
   output logic               vga_blank_n
);
   import vision_pkg::*;

   // Stages ahead of the output register
   localparam int PIPE = OUT_LAT - 1;

   logic [PIPE-1:0] hs_pipe;
   logic [PIPE-1:0] vs_pipe;
   logic [PIPE-1:0] bl_pipe;
   coord_t          hc_pipe [PIPE];
   pixel_t          bar_pixel;
   pixel_t          sel_pixel;

   //////////////////////////////////////////////////
   // Sync and position alignment
   //////////////////////////////////////////////////

   // Idle as blanked with syncs high
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         hs_pipe <= '1;
         vs_pipe <= '1;
         bl_pipe <= '1;
      end else begin
         hs_pipe <= {hs_pipe[PIPE-2:0], hsync_n};
         vs_pipe <= {vs_pipe[PIPE-2:0], vsync_n};
         bl_pipe <= {bl_pipe[PIPE-2:0], blank};
      end
   end

   // Position for the bar pattern
   always_ff @(posedge clk) begin
      hc_pipe[0] <= hcount;
      for (int i = 1; i < PIPE; i++) begin
         hc_pipe[i] <= hc_pipe[i-1];
      end
   end

   //////////////////////////////////////////////////
   // Pixel select and output register
   //////////////////////////////////////////////////

   // Eight vertical bars, each 64 pixels wide
   assign bar_pixel = {hc_pipe[PIPE-1][BAR_SHIFT+2:BAR_SHIFT], 5'b00000};
   assign sel_pixel = bars_sel ? bar_pixel : ov_pixel;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         vga_gray    <= '0;
         vga_hsync_n <= 1'b1;
         vga_vsync_n <= 1'b1;
         vga_blank_n <= 1'b0;
      end else begin
         vga_gray    <= bl_pipe[PIPE-1] ? '0 : sel_pixel;   // black in blanking
         vga_hsync_n <= hs_pipe[PIPE-1];
         vga_vsync_n <= vs_pipe[PIPE-1];
         vga_blank_n <= !bl_pipe[PIPE-1];
      end
   end

endmodule

// ==== hdl/marker_overlay.sv ====
`timescale 1ns/1ns

module marker_overlay #(
   parameter int N_MARKERS = 4
) (
   input  logic               clk,
   input  logic               arst_n,
   // Counter position, lined up with fb_pixel by the delay line below
   input  vision_pkg::coord_t hcount_d,
   input  vision_pkg::coord_t vcount_d,
   input  vision_pkg::pixel_t fb_pixel,
   input  vision_pkg::coord_t marker_left   [N_MARKERS],
   input  vision_pkg::coord_t marker_right  [N_MARKERS],
   input  vision_pkg::coord_t marker_top    [N_MARKERS],
   input  vision_pkg::coord_t marker_bottom [N_MARKERS],
   output vision_pkg::pixel_t ov_pixel
);
   import vision_pkg::*;

   coord_t h_pipe [FETCH_LAT];
   coord_t v_pipe [FETCH_LAT];
   logic   hit;

   //////////////////////////////////////////////////
   // Coordinate delay
   //////////////////////////////////////////////////

   // Matches the fetch latency so the test sees the
   // position of the pixel now on fb_pixel
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < FETCH_LAT; i++) begin
            h_pipe[i] <= '0;
            v_pipe[i] <= '0;
         end
      end else begin
         h_pipe[0] <= hcount_d;
         v_pipe[0] <= vcount_d;
         for (int i = 1; i < FETCH_LAT; i++) begin
            h_pipe[i] <= h_pipe[i-1];
            v_pipe[i] <= v_pipe[i-1];
         end
      end
   end

   //////////////////////////////////////////////////
   // Box hit test and merge
   //////////////////////////////////////////////////

   // Half-open boxes, right and bottom edges excluded
   // A box with left >= right or top >= bottom never hits
   always_comb begin
      hit = 1'b0;
      for (int m = 0; m < N_MARKERS; m++) begin
         if ((h_pipe[FETCH_LAT-1] >= marker_left[m]) &&
             (h_pipe[FETCH_LAT-1] <  marker_right[m]) &&
             (v_pipe[FETCH_LAT-1] >= marker_top[m]) &&
             (v_pipe[FETCH_LAT-1] <  marker_bottom[m])) begin
            hit = 1'b1;
         end
      end
   end

   // Overlapping boxes give the same result as one box
   always_ff @(posedge clk) begin
      ov_pixel <= hit ? (fb_pixel | MARKER_LEVEL) : fb_pixel;
   end

endmodule

// ==== hdl/vram_pixel_fetch.sv ====
`timescale 1ns/1ns

module vram_pixel_fetch #(
   parameter int H_TOTAL        = 1056,
   parameter int V_TOTAL        = 628,
   parameter int WORDS_PER_LINE = 200
) (
   input  logic                   clk,
   input  logic                   arst_n,
   input  vision_pkg::coord_t     hcount,
   input  vision_pkg::coord_t     vcount,
   input  vision_pkg::vram_word_t vram_rdata,
   output vision_pkg::vram_addr_t rd_addr,
   output vision_pkg::pixel_t     fb_pixel
);
   import vision_pkg::*;

   logic                   rd_slot;
   logic                   last_slot;
   coord_t                 next_line;
   logic [VRAM_RD_LAT-1:0] slot_pipe;
   logic [1:0]             lane_pipe [FETCH_LAT-1];
   vram_word_t             word_q;
   vram_word_t             show_q;

   //////////////////////////////////////////////////
   // Look-ahead address
   //////////////////////////////////////////////////

   // Read slot is the first pixel of each word
   assign rd_slot   = (hcount[1:0] == 2'd0);
   // Last slot of a line fetches word 0 of the line after it
   assign last_slot = (hcount == coord_t'(H_TOTAL - PIX_PER_WORD));
   assign next_line = (vcount == coord_t'(V_TOTAL - 1)) ? '0 : vcount + coord_t'(1);

   // Slot of word w asks for word w+1
   // Addresses issued in blanking are never displayed
   always_comb begin
      if (last_slot) begin
         rd_addr = vram_addr_t'(next_line) * vram_addr_t'(WORDS_PER_LINE);
      end else begin
         rd_addr = vram_addr_t'(vcount) * vram_addr_t'(WORDS_PER_LINE) +
                   vram_addr_t'(hcount[10:2]) + vram_addr_t'(1);
      end
   end

   //////////////////////////////////////////////////
   // Slot and lane tracking
   //////////////////////////////////////////////////

   // slot_pipe marks the cycle the SRAM answers
   // lane_pipe carries the pixel lane toward the select mux
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         slot_pipe <= '0;
         for (int i = 0; i < FETCH_LAT - 1; i++) begin
            lane_pipe[i] <= '0;
         end
      end else begin
         slot_pipe    <= {slot_pipe[VRAM_RD_LAT-2:0], rd_slot};
         lane_pipe[0] <= hcount[1:0];
         for (int i = 1; i < FETCH_LAT - 1; i++) begin
            lane_pipe[i] <= lane_pipe[i-1];
         end
      end
   end

   //////////////////////////////////////////////////
   // Word latch and pixel select
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      // Catch the word 3 cycles after its slot
      if (slot_pipe[VRAM_RD_LAT-1]) begin
         word_q <= vram_rdata;
      end
      // Delayed word start hands it to the display register
      // before the next fetch overwrites word_q
      if (lane_pipe[0] == 2'd0) begin
         show_q <= word_q;
      end
      // Lane 0 is the low byte
      fb_pixel <= show_q[{lane_pipe[FETCH_LAT-2], 3'b000} +: 8];
   end

endmodule

// ==== hdl/vram_arbiter.sv ====
`timescale 1ns/1ns

module vram_arbiter (
   input  logic                   clk,
   input  logic                   arst_n,
   input  vision_pkg::coord_t     hcount,
   input  logic                   blank,
   input  logic                   pattern_en,
   input  logic                   pattern_period,
   input  vision_pkg::vram_addr_t rd_addr,
   output vision_pkg::vram_addr_t vram_addr,
   output logic                   vram_we,
   output vision_pkg::vram_word_t vram_wdata
);
   import vision_pkg::*;

   // Slot phase within each group of four pixel clocks
   // Phase 0 belongs to the pixel fetch
   localparam logic [1:0] WR_PHASE = 2'd2;

   vram_addr_t wr_cnt;
   logic       wr_slot;
   pixel_t     pat_byte;

   //////////////////////////////////////////////////
   // Slot decision
   //////////////////////////////////////////////////

   // One SRAM word feeds four pixels, so only every fourth
   // cycle is needed for display reads
   // Writes take phase 2, never the read phase
   // Blank keeps writes out of the visible area entirely
   assign wr_slot = (hcount[1:0] == WR_PHASE) && blank && pattern_en;

   // Memory port mux
   // Every non-write cycle shows the fetch address
   assign vram_we   = wr_slot;
   assign vram_addr = wr_slot ? wr_cnt : rd_addr;

   //////////////////////////////////////////////////
   // Test-pattern writer
   //////////////////////////////////////////////////

   // Grey step per address group
   // Short period uses bits 6:3, long period bits 7:4
   always_comb begin
      if (pattern_period) begin
         pat_byte = {wr_cnt[6:3], 4'b0000};
      end else begin
         pat_byte = {wr_cnt[7:4], 4'b0000};
      end
   end

   // Same byte in every lane of the word
   assign vram_wdata = {PIX_PER_WORD{pat_byte}};

   // Write address counter
   // Steps once per accepted write and wraps at the top
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_cnt <= '0;
      end else if (wr_slot) begin
         wr_cnt <= wr_cnt + vram_addr_t'(1);
      end
   end

endmodule

// ==== hdl/video_timing.sv ====
`timescale 1ns/1ns

module video_timing #(
   parameter int H_ACTIVE = 800,
   parameter int H_FP     = 40,
   parameter int H_SYNC   = 128,
   parameter int H_BP     = 88,
   parameter int V_ACTIVE = 600,
   parameter int V_FP     = 1,
   parameter int V_SYNC   = 4,
   parameter int V_BP     = 23
) (
   input  logic               clk,
   input  logic               arst_n,
   output vision_pkg::coord_t hcount,
   output vision_pkg::coord_t vcount,
   output logic               hsync_n,
   output logic               vsync_n,
   output logic               blank
);
   import vision_pkg::*;

   // Line and frame lengths including porches
   localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
   localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;

   // Sync pulse window starts after the front porch
   localparam int H_SYNC_START = H_ACTIVE + H_FP;
   localparam int V_SYNC_START = V_ACTIVE + V_FP;

   coord_t h_next;
   coord_t v_next;
   logic   h_wrap;

   //////////////////////////////////////////////////
   // Next counter position
   //////////////////////////////////////////////////

   always_comb begin
      h_wrap = (hcount == coord_t'(H_TOTAL - 1));
      h_next = h_wrap ? '0 : hcount + coord_t'(1);
      // Vertical counter only steps at end of line
      if (h_wrap) begin
         v_next = (vcount == coord_t'(V_TOTAL - 1)) ? '0 : vcount + coord_t'(1);
      end else begin
         v_next = vcount;
      end
   end

   //////////////////////////////////////////////////
   // Registered counters and sync decode
   //////////////////////////////////////////////////

   // Syncs and blank are decoded from the next position
   // so they line up with the counters on the same cycle
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         hcount  <= '0;
         vcount  <= '0;
         hsync_n <= 1'b1;
         vsync_n <= 1'b1;
         // Position 0,0 is inside the active area
         blank   <= 1'b0;
      end else begin
         hcount  <= h_next;
         vcount  <= v_next;
         hsync_n <= !((h_next >= coord_t'(H_SYNC_START)) &&
                      (h_next < coord_t'(H_SYNC_START + H_SYNC)));
         vsync_n <= !((v_next >= coord_t'(V_SYNC_START)) &&
                      (v_next < coord_t'(V_SYNC_START + V_SYNC)));
         blank   <= (h_next >= coord_t'(H_ACTIVE)) || (v_next >= coord_t'(V_ACTIVE));
      end
   end

endmodule

// ==== hdl/vision_pkg.sv ====
package vision_pkg;

   //////////////////////////////////////////////////
   // Pixel and screen geometry
   //////////////////////////////////////////////////

   // Screen coordinate, wide enough for any counter value up to 2047
   typedef logic [10:0] coord_t;

   // Grey level of one displayed pixel
   typedef logic [7:0] pixel_t;

   //////////////////////////////////////////////////
   // Frame buffer memory
   //////////////////////////////////////////////////

   // One SRAM word carries four pixels
   // Pixel 0 sits in the low byte
   typedef logic [31:0] vram_word_t;

   // Word address into the SRAM
   typedef logic [18:0] vram_addr_t;

   // Pixels packed in one memory word
   localparam int PIX_PER_WORD = 4;

   // Cycles from the address edge until read data is valid
   localparam int VRAM_RD_LAT = 2;

   //////////////////////////////////////////////////
   // Display pipeline
   //////////////////////////////////////////////////

   // Cycles from hcount to fb_pixel inside the fetch block
   localparam int FETCH_LAT = 3;

   // Cycles from hcount to the output pins
   // Fetch plus overlay register plus output register
   localparam int OUT_LAT = FETCH_LAT + 2;

   // Level OR-ed into pixels that fall inside a marker box
   localparam pixel_t MARKER_LEVEL = 8'd200;

   // First hcount bit of the test-bar index
   // Bar pixel is three hcount bits with five zero bits below
   localparam int BAR_SHIFT = 6;

endpackage
